/* all.f */
src/board_pkg.sv
src/piece_pkg.sv
src/board_ram.sv
src/board_arbiter.sv
src/collision_checker.sv
src/piece_mover.sv
src/line_clearer.sv
src/playfield_top.sv
verif/playfield_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = playfield_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* verif/playfield_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module playfield_tb
    import board_pkg::*;
    import piece_pkg::*;
();

    localparam int   ROWS     = 24;
    localparam int   N_CMDS   = 710;  // upper bound on commands over all tests
    localparam int   N_READS  = 140;  // upper bound on host row reads
    localparam int   WATCHDOG = 8 + ROWS + N_CMDS * 300 + N_READS * 40;
    localparam row_t BLANK    = {10{6'd37}};

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    logic        cmd_ready;
    piece_cmd_t  cmd;
    logic        resp_valid;
    logic        resp_ready;
    piece_resp_t resp;
    logic        rd_valid;
    logic        rd_ready;
    logic [4:0]  rd_row;
    logic        rd_data_valid;
    row_t        rd_data;

    integer      seed;
    row_t        board_m [ROWS]; // expected board contents
    logic        m_active;
    mask_t       m_mask;
    logic [5:0]  m_colour;
    int          m_col;
    int          m_row;

    playfield_top #(.BOARD_ROWS(ROWS)) i_playfield_top (
        .clk (clk), .rst (rst), .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd (cmd),
        .resp_valid (resp_valid), .resp_ready (resp_ready), .resp (resp),
        .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_row (rd_row),
        .rd_data_valid (rd_data_valid), .rd_data (rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        repeat (WATCHDOG) @(posedge clk);
        $display("simulation timed out before all tests finished");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // a piece fits when all its cells are inside the walls, above the floor and on empty cells
    function automatic logic model_fits(input mask_t m, input int col, input int row);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < 16; i++)
        begin
            if (m[i])
            begin
                if ((col + i % 4) < 0 || (col + i % 4) > 9 || (row + i / 4) >= ROWS)
                    ok = 1'b0;
                else if (board_m[row + i / 4][col + i % 4] != 6'd37)
                    ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // paint the active piece, then drop full rows and pull the rest down
    function automatic int model_lock();
        row_t next [ROWS];
        int   w;
        int   n;
        logic full;
        for (int i = 0; i < 16; i++)
        begin
            if (m_mask[i])
                board_m[m_row + i / 4][m_col + i % 4] = m_colour;
        end
        for (int r = 0; r < ROWS; r++)
            next[r] = BLANK;
        w = ROWS - 1;
        n = 0;
        for (int r = ROWS - 1; r >= 0; r--)
        begin
            full = 1'b1;
            for (int c = 0; c < 10; c++)
            begin
                if (board_m[r][c] == 6'd37)
                    full = 1'b0;
            end
            if (full)
                n++;
            else
            begin
                next[w] = board_m[r];
                w--;
            end
        end
        board_m = next;
        return n;
    endfunction

    function automatic piece_resp_t model_cmd(input piece_cmd_t c);
        piece_resp_t e;
        mask_t       nm;
        int          nc;
        int          nr;
        logic        ok;
        nm = (c.op == OP_SPAWN) ? c.mask : m_mask;
        nc = (c.op == OP_SPAWN) ? int'(c.pos.col) : m_col;
        nr = (c.op == OP_SPAWN) ? int'(c.pos.row) : m_row;
        case (c.op)
            OP_LEFT:  nc = nc - 1;
            OP_RIGHT: nc = nc + 1;
            OP_DOWN:  nr = nr + 1;
            default:  ;
        endcase
        ok = model_fits(nm, nc, nr);
        e.lines = 3'd0;
        if (c.op == OP_SPAWN && !ok)
        begin
            e.status = ST_GAME_OVER;
            m_active = 1'b0;
        end
        else if (ok && (m_active || c.op == OP_SPAWN))
        begin
            e.status = ST_MOVED;
            if (c.op == OP_SPAWN)
                m_colour = c.colour;
            m_mask   = nm;
            m_col    = nc;
            m_row    = nr;
            m_active = 1'b1;
        end
        else if (m_active && c.op == OP_DOWN)
        begin
            e.lines  = 3'(model_lock()); // piece rests where it is
            e.status = ST_LOCKED;
            m_active = 1'b0;
        end
        else
            e.status = ST_BLOCKED;
        e.pos.col = 5'(m_col);
        e.pos.row = 5'(m_row);
        return e;
    endfunction

    function automatic piece_cmd_t make_cmd(input piece_op_e op, input mask_t m,
                                            input logic [5:0] colour, input int col,
                                            input int row);
        piece_cmd_t c;
        c.op      = op;
        c.mask    = m;
        c.colour  = colour;
        c.pos.col = 5'(col);
        c.pos.row = 5'(row);
        return c;
    endfunction

    function automatic mask_t pick_mask();
        case ($unsigned($random(seed)) % 5)
            0:       return 16'h000F; // flat bar
            1:       return 16'h0033; // square
            2:       return 16'h0027; // tee
            3:       return 16'h2222; // upright bar
            default: return 16'h0311; // ell
        endcase
    endfunction

    task automatic send_cmd(input piece_cmd_t c);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        do
            @(posedge clk);
        while (!cmd_ready);
        cmd_valid <= 1'b0;
    endtask

    task automatic take_resp(input string name, input piece_resp_t exp, input logic stall,
                             output piece_resp_t got);
        piece_resp_t held;
        logic        seen;
        logic        done;
        seen = 1'b0;
        done = 1'b0;
        while (!done)
        begin
            resp_ready <= stall ? 1'($random(seed)) : 1'b1;
            @(posedge clk);
            if (resp_valid && seen)
                check({name, "_stable"}, 64'(held), 64'(resp)); // must not change while stalled
            if (resp_valid)
            begin
                held = resp;
                seen = 1'b1;
            end
            done = resp_valid && resp_ready;
        end
        got = resp;
        check(name, 64'(exp), 64'(got));
    endtask

    task automatic do_cmd(input string name, input piece_cmd_t c, input logic stall,
                          output piece_resp_t got);
        piece_resp_t e;
        e = model_cmd(c);
        send_cmd(c);
        take_resp(name, e, stall, got);
    endtask

    task automatic drop_to_lock(input string name, output piece_resp_t got);
        int n;
        n = 0;
        do
        begin
            do_cmd(name, make_cmd(OP_DOWN, '0, '0, 0, 0), 1'b0, got);
            n++;
        end
        while (got.status != ST_LOCKED && n < 30);
        check({name, "_locked"}, 64'(ST_LOCKED), 64'(got.status));
    endtask

    task automatic read_row(input string name, input int row);
        @(posedge clk);
        rd_valid <= 1'b1;
        rd_row   <= 5'(row);
        do
            @(posedge clk);
        while (!rd_ready);
        rd_valid <= 1'b0;
        do
            @(posedge clk);
        while (!rd_data_valid);
        check(name, 64'(board_m[row]), 64'(rd_data));
    endtask

    initial
    begin
        piece_resp_t r;
        mask_t       m;
        logic [5:0]  colour;
        int          col;
        int          found_r;
        int          found_c;
        logic        cleared;
        integer      rd_seed;

        seed       = 32'h864b;
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        resp_ready = 1'b0;
        rd_valid   = 1'b0;
        rd_row     = '0;
        m_active   = 1'b0;
        m_mask     = '0;
        m_colour   = '0;
        m_col      = 0;
        m_row      = 0;
        for (int i = 0; i < ROWS; i++)
            board_m[i] = BLANK;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < ROWS; i++)
            read_row("reset_read", i);

        // spawn, then push against both walls
        colour = 6'($unsigned($random(seed)) % 37);
        do_cmd("spawn_empty", make_cmd(OP_SPAWN, pick_mask(), colour, 3, 0), 1'b0, r);
        check("spawn_empty_status", 64'(ST_MOVED), 64'(r.status));
        repeat (12) do_cmd("move_left", make_cmd(OP_LEFT, '0, '0, 0, 0), 1'b0, r);
        repeat (14) do_cmd("move_right", make_cmd(OP_RIGHT, '0, '0, 0, 0), 1'b0, r);
        repeat (10)
            do_cmd("move_side", make_cmd(($random(seed) & 1) ? OP_LEFT : OP_RIGHT,
                                         '0, '0, 0, 0), 1'b0, r);

        // random piece at a random column falls until it locks
        m = pick_mask();
        do
            col = int'($unsigned($random(seed)) % 13) - 3;
        while (!model_fits(m, col, 0));
        colour = 6'($unsigned($random(seed)) % 37);
        do_cmd("spawn_random", make_cmd(OP_SPAWN, m, colour, col, 0), 1'b0, r);
        drop_to_lock("drop_random", r);
        for (int i = 0; i < ROWS; i++)
            read_row("lock_read", i);

        // two bars and a square per round until some row completes
        cleared = 1'b0;
        for (int k = 0; k < 18 && !cleared; k++)
        begin
            colour = 6'($unsigned($random(seed)) % 37);
            if (k % 3 == 2)
                do_cmd("spawn_fill", make_cmd(OP_SPAWN, 16'h0033, colour, 8, 0), 1'b0, r);
            else
                do_cmd("spawn_fill", make_cmd(OP_SPAWN, 16'h000F, colour, (k % 3) * 4, 0),
                       1'b0, r);
            drop_to_lock("drop_fill", r);
            if (r.lines != 3'd0)
                cleared = 1'b1;
        end
        check("row_cleared", 64'd1, 64'(cleared));
        for (int i = 0; i < ROWS; i++)
            read_row("clear_read", i);

        // extra bar so the board surely holds blocks
        do_cmd("spawn_extra", make_cmd(OP_SPAWN, 16'h000F, 6'd9, 0, 0), 1'b0, r);
        drop_to_lock("drop_extra", r);
        do_cmd("move_inactive", make_cmd(OP_LEFT, '0, '0, 0, 0), 1'b0, r);
        check("move_inactive_status", 64'(ST_BLOCKED), 64'(r.status));
        found_r = -1;
        found_c = 0;
        for (int rr = 0; rr < ROWS; rr++)
        begin
            for (int cc = 0; cc < 10; cc++)
            begin
                if (board_m[rr][cc] != 6'd37)
                begin
                    found_r = rr;
                    found_c = cc;
                end
            end
        end
        check("occupied_cell_found", 64'd1, 64'(found_r >= 0));
        do_cmd("spawn_occupied", make_cmd(OP_SPAWN, 16'h0001, 6'd5, found_c, found_r), 1'b0, r);
        check("game_over_status", 64'(ST_GAME_OVER), 64'(r.status));
        do_cmd("down_inactive", make_cmd(OP_DOWN, '0, '0, 0, 0), 1'b0, r);
        check("down_inactive_status", 64'(ST_BLOCKED), 64'(r.status));

        // side moves with a stalling host while rows are read alongside
        do_cmd("spawn_top", make_cmd(OP_SPAWN, 16'h0027, 6'd12, 3, 0), 1'b0, r);
        rd_seed = seed + 1;
        fork
            begin
                repeat (40)
                    do_cmd("stall_move", make_cmd(($random(seed) & 1) ? OP_LEFT : OP_RIGHT,
                                                  '0, '0, 0, 0), 1'b1, r);
            end
            begin
                repeat (30)
                    read_row("stall_read", int'($unsigned($random(rd_seed)) % ROWS));
            end
        join

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* src/playfield_top.sv */
`timescale 1ns/1ns
`default_nettype none

module playfield_top
    import board_pkg::*;
    import piece_pkg::*;
#(
    parameter int BOARD_ROWS = 24
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  piece_cmd_t  cmd,
    output logic        resp_valid,
    input  logic        resp_ready,
    output piece_resp_t resp,
    input  logic        rd_valid,
    output logic        rd_ready,
    input  logic [4:0]  rd_row,
    output logic        rd_data_valid,
    output row_t        rd_data
);

    logic       mv_req_valid, cl_req_valid;
    ram_req_t   mv_req, cl_req;
    ram_req_t   arb_req [3];
    logic [2:0] gnt, rvalid;
    row_t       rdata, ram_rdata, ram_wdata;
    logic       ram_we, init_busy, clear_start, clear_done;
    logic [4:0] ram_addr;
    logic [2:0] lines;

    assign arb_req[0]    = mv_req;
    assign arb_req[1]    = cl_req;
    assign arb_req[2]    = '{write: 1'b0, row: rd_row, wdata: EMPTY_ROW}; // host only reads
    assign rd_ready      = gnt[2];
    assign rd_data_valid = rvalid[2];
    assign rd_data       = rdata;

    board_ram #(.BOARD_ROWS(BOARD_ROWS)) i_board_ram (
        .clk (clk), .rst (rst), .we (ram_we), .addr (ram_addr), .wdata (ram_wdata),
        .rdata (ram_rdata), .init_busy (init_busy)
    );

    board_arbiter #(.BOARD_ROWS(BOARD_ROWS)) i_board_arbiter (
        .clk (clk), .rst (rst), .req_valid ({rd_valid, cl_req_valid, mv_req_valid}),
        .req (arb_req), .gnt (gnt), .rvalid (rvalid), .rdata (rdata), .init_busy (init_busy),
        .we (ram_we), .addr (ram_addr), .wdata (ram_wdata), .ram_rdata (ram_rdata)
    );

    piece_mover #(.BOARD_ROWS(BOARD_ROWS)) i_piece_mover (
        .clk (clk), .rst (rst), .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd (cmd),
        .resp_valid (resp_valid), .resp_ready (resp_ready), .resp (resp),
        .req_valid (mv_req_valid), .req (mv_req), .gnt (gnt[0]), .rvalid (rvalid[0]),
        .rdata (rdata), .clear_start (clear_start), .clear_done (clear_done), .lines (lines)
    );

    line_clearer #(.BOARD_ROWS(BOARD_ROWS)) i_line_clearer (
        .clk (clk), .rst (rst), .clear_start (clear_start), .clear_done (clear_done),
        .lines (lines), .req_valid (cl_req_valid), .req (cl_req), .gnt (gnt[1]),
        .rvalid (rvalid[1]), .rdata (rdata)
    );

endmodule

`default_nettype wire

/* src/line_clearer.sv */
`timescale 1ns/1ns
`default_nettype none

module line_clearer
    import board_pkg::*;
#(
    parameter int BOARD_ROWS = 24
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       clear_start,
    output logic       clear_done,
    output logic [2:0] lines,
    output logic       req_valid,
    output ram_req_t   req,
    input  logic       gnt,
    input  logic       rvalid,
    input  row_t       rdata
);

    typedef enum logic [2:0] {C_IDLE, C_READ, C_WAIT, C_WRITE, C_FILL, C_DONE} state_e;

    state_e     state;
    logic [4:0] rd_ptr;
    logic [5:0] wr_ptr; // bit 5 set means the pointer ran past row 0
    logic [2:0] cnt;
    row_t       row_q;

    function automatic logic row_full(input row_t r);
        logic full;
        full = 1'b1;
        for (int c = 0; c < BOARD_COLS; c++)
        begin
            if (r[c] == CELL_EMPTY)
                full = 1'b0;
        end
        return full;
    endfunction

    assign req_valid  = (state == C_READ) || (state == C_WRITE) || (state == C_FILL && !wr_ptr[5]);
    assign req        = '{write: (state != C_READ),
                          row: (state == C_READ) ? rd_ptr : wr_ptr[4:0],
                          wdata: (state == C_FILL) ? EMPTY_ROW : row_q};
    assign clear_done = (state == C_DONE);
    assign lines      = cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= C_IDLE;
            rd_ptr <= '0;
            wr_ptr <= '0;
            cnt    <= '0;
        end
        else
        begin
            case (state)
                C_IDLE:
                    if (clear_start)
                    begin
                        rd_ptr <= 5'(BOARD_ROWS - 1); // start from the floor
                        wr_ptr <= 6'(BOARD_ROWS - 1);
                        cnt    <= '0;
                        state  <= C_READ;
                    end
                C_READ:
                    if (gnt)
                        state <= C_WAIT;
                C_WAIT:
                    if (rvalid)
                    begin
                        row_q <= rdata;
                        if (row_full(rdata))
                        begin
                            cnt    <= cnt + 3'd1; // full row is dropped
                            rd_ptr <= rd_ptr - 5'd1;
                            state  <= (rd_ptr == '0) ? C_FILL : C_READ;
                        end
                        else
                            state <= C_WRITE;
                    end
                C_WRITE:
                    if (gnt)
                    begin
                        wr_ptr <= wr_ptr - 6'd1;
                        rd_ptr <= rd_ptr - 5'd1;
                        state  <= (rd_ptr == '0) ? C_FILL : C_READ;
                    end
                C_FILL:
                    if (wr_ptr[5])
                        state <= C_DONE;
                    else if (gnt)
                        wr_ptr <= wr_ptr - 6'd1;
                C_DONE:
                    state <= C_IDLE;
                default:
                    state <= C_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/piece_mover.sv */
`timescale 1ns/1ns
`default_nettype none

module piece_mover
    import board_pkg::*;
    import piece_pkg::*;
#(
    parameter int BOARD_ROWS = 24
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  piece_cmd_t  cmd,
    output logic        resp_valid,
    input  logic        resp_ready,
    output piece_resp_t resp,
    output logic        req_valid,
    output ram_req_t    req,
    input  logic        gnt,
    input  logic        rvalid,
    input  row_t        rdata,
    output logic        clear_start,
    input  logic        clear_done,
    input  logic [2:0]  lines
);

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_WAIT, S_DECIDE, S_LOCK, S_CLEAR, S_CLEAR_WAIT, S_RESP
    } state_e;

    state_e            state;
    piece_op_e         op_q;
    mask_t             cur_mask, cand_mask;
    logic [CELL_W-1:0] cur_colour, cand_colour;
    pos_t              cur_pos, cand_pos;
    logic              active;
    logic              locking; // window fetch is for the lock write, not a test
    logic [1:0]        idx;
    row_t              win [4];
    piece_status_e     status_q;
    logic [2:0]        lines_q;
    logic              fits;
    logic [3:0]        lock_bits;

    // paint the piece cells of one mask row into a board row
    function automatic row_t merge_row(input row_t base, input logic [3:0] bits,
                                       input logic signed [4:0] col,
                                       input logic [CELL_W-1:0] colour);
        row_t              r;
        logic signed [5:0] c_abs;
        r = base;
        for (int c = 0; c < 4; c++)
        begin
            c_abs = 6'(col) + 6'(c);
            if (bits[c] && c_abs >= 0 && c_abs < BOARD_COLS)
                r[c_abs[3:0]] = colour;
        end
        return r;
    endfunction

    collision_checker #(.BOARD_ROWS(BOARD_ROWS)) i_collision_checker (
        .mask (cand_mask),
        .pos  (cand_pos),
        .rows (win),
        .fits (fits)
    );

    assign lock_bits   = cur_mask[idx * 4 +: 4];
    assign cmd_ready   = (state == S_IDLE);
    assign resp_valid  = (state == S_RESP);
    assign clear_start = (state == S_CLEAR);
    assign resp        = '{status: status_q, pos: cur_pos, lines: lines_q};
    assign req_valid   = (state == S_FETCH) || (state == S_LOCK && |lock_bits);
    // during a lock cand_pos holds the current position
    assign req = '{write: (state == S_LOCK), row: cand_pos.row + 5'(idx),
                   wdata: merge_row(win[idx], lock_bits, cur_pos.col, cur_colour)};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= S_IDLE;
            active  <= 1'b0;
            locking <= 1'b0;
            idx     <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (cmd_valid)
                    begin
                        op_q        <= cmd.op;
                        idx         <= '0;
                        locking     <= 1'b0;
                        lines_q     <= '0;
                        cand_mask   <= (cmd.op == OP_SPAWN) ? cmd.mask : cur_mask;
                        cand_colour <= (cmd.op == OP_SPAWN) ? cmd.colour : cur_colour;
                        cand_pos    <= cur_pos;
                        case (cmd.op)
                            OP_SPAWN: cand_pos     <= cmd.pos;
                            OP_LEFT:  cand_pos.col <= cur_pos.col - 5'sd1;
                            OP_RIGHT: cand_pos.col <= cur_pos.col + 5'sd1;
                            OP_DOWN:  cand_pos.row <= cur_pos.row + 5'd1;
                        endcase
                        state <= S_FETCH;
                    end
                S_FETCH:
                    if (gnt)
                        state <= S_WAIT;
                S_WAIT:
                    if (rvalid)
                    begin
                        win[idx] <= rdata;
                        idx      <= idx + 2'd1; // wraps to 0 after the fourth row
                        if (idx == 2'd3)
                            state <= locking ? S_LOCK : S_DECIDE;
                        else
                            state <= S_FETCH;
                    end
                S_DECIDE:
                begin
                    state    <= S_RESP;
                    status_q <= ST_BLOCKED;
                    if (op_q == OP_SPAWN && !fits)
                    begin
                        status_q <= ST_GAME_OVER;
                        active   <= 1'b0;
                    end
                    else if (fits && (active || op_q == OP_SPAWN))
                    begin
                        status_q   <= ST_MOVED;
                        cur_pos    <= cand_pos;
                        cur_mask   <= cand_mask;
                        cur_colour <= cand_colour;
                        active     <= 1'b1;
                    end
                    else if (active && op_q == OP_DOWN)
                    begin
                        locking  <= 1'b1; // refetch the rows the piece sits in now
                        cand_pos <= cur_pos;
                        state    <= S_FETCH;
                    end
                end
                S_LOCK:
                    if (!(|lock_bits) || gnt)
                    begin
                        idx <= idx + 2'd1;
                        if (idx == 2'd3)
                            state <= S_CLEAR;
                    end
                S_CLEAR:
                    state <= S_CLEAR_WAIT;
                S_CLEAR_WAIT:
                    if (clear_done)
                    begin
                        lines_q  <= lines;
                        status_q <= ST_LOCKED;
                        active   <= 1'b0;
                        state    <= S_RESP;
                    end
                S_RESP:
                    if (resp_ready)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/collision_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module collision_checker
    import board_pkg::*;
    import piece_pkg::*;
#(
    parameter int BOARD_ROWS = 24
)
(
    input  mask_t mask,
    input  pos_t  pos,
    input  row_t  rows [4],
    output logic  fits
);

    always_comb
    begin
        logic signed [5:0] c_abs;
        logic        [5:0] r_abs;

        fits = 1'b1;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                c_abs = 6'(pos.col) + 6'(c); // sign extended board column
                r_abs = 6'(pos.row) + 6'(r);
                if (mask[r * 4 + c])
                begin
                    if (c_abs < 0 || c_abs >= BOARD_COLS)
                        fits = 1'b0; // wall
                    else if (r_abs >= BOARD_ROWS)
                        fits = 1'b0; // floor, the window row content does not matter here
                    else if (rows[r][c_abs[3:0]] != CELL_EMPTY)
                        fits = 1'b0; // saved block
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/board_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module board_arbiter
    import board_pkg::*;
#(
    parameter int BOARD_ROWS = 24
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] req_valid,
    input  ram_req_t   req [3],
    output logic [2:0] gnt,
    output logic [2:0] rvalid,
    output row_t       rdata,
    input  logic       init_busy,
    output logic       we,
    output logic [4:0] addr,
    output row_t       wdata,
    input  row_t       ram_rdata
);

    logic [1:0] last; // slot of the previous winner
    logic [1:0] sel;
    logic       oob;  // row index past the bottom of the board
    logic       oob_q;
    ram_req_t   win_req;

    always_comb
    begin
        sel = last;
        // walk backwards so the slot right after the last winner is taken first
        for (int i = 3; i >= 1; i--)
        begin
            if (req_valid[(last + i) % 3])
                sel = 2'((last + i) % 3);
        end
        gnt = '0;
        if (!init_busy && |req_valid)
            gnt[sel] = 1'b1;
    end

    assign win_req = req[sel];
    assign oob     = (win_req.row >= BOARD_ROWS);
    assign we      = |gnt && win_req.write && !oob; // rows off the board are never written
    assign addr    = win_req.row;
    assign wdata   = win_req.wdata;
    assign rdata   = oob_q ? EMPTY_ROW : ram_rdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last   <= 2'd2; // mover gets the first turn
            rvalid <= '0;
        end
        else
        begin
            rvalid <= gnt & {3{!win_req.write}};
            if (|gnt)
                last <= sel;
        end
    end

    always_ff @(posedge clk)
    begin
        oob_q <= oob;
    end

endmodule

`default_nettype wire

/* src/board_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module board_ram
    import board_pkg::*;
#(
    parameter int BOARD_ROWS = 24
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       we,
    input  logic [4:0] addr,
    input  row_t       wdata,
    output row_t       rdata,
    output logic       init_busy
);

    logic [ROW_W-1:0] mem [BOARD_ROWS];
    logic [4:0]       init_ptr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            init_busy <= 1'b1;
            init_ptr  <= '0;
        end
        else if (init_busy)
        begin
            init_ptr <= init_ptr + 5'd1;
            if (init_ptr == 5'(BOARD_ROWS - 1))
                init_busy <= 1'b0; // last row blanked this cycle
        end
    end

    always_ff @(posedge clk)
    begin
        if (init_busy)
            mem[init_ptr] <= EMPTY_ROW;
        else if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr]; // registered read, one cycle of latency
    end

endmodule

`default_nettype wire

/* src/piece_pkg.sv */
`default_nettype none

package piece_pkg;

    import board_pkg::CELL_W;

    // bit row*4+col, row 0 at the top and col 0 at the left
    typedef logic [15:0] mask_t;

    typedef struct packed {
        logic signed [4:0] col; // may go negative when the left mask columns are empty
        logic        [4:0] row;
    } pos_t;

    typedef enum logic [1:0] {
        OP_SPAWN,
        OP_LEFT,
        OP_RIGHT,
        OP_DOWN
    } piece_op_e;

    typedef struct packed {
        piece_op_e         op;
        mask_t             mask;   // spawn only
        logic [CELL_W-1:0] colour; // spawn only
        pos_t              pos;    // spawn only
    } piece_cmd_t;

    typedef enum logic [1:0] {
        ST_MOVED,
        ST_BLOCKED,
        ST_LOCKED,
        ST_GAME_OVER
    } piece_status_e;

    typedef struct packed {
        piece_status_e status;
        pos_t          pos;
        logic [2:0]    lines;
    } piece_resp_t;

endpackage

`default_nettype wire

/* src/board_pkg.sv */
`default_nettype none

package board_pkg;

    localparam int BOARD_COLS = 10;
    localparam int CELL_W     = 6;
    localparam int ROW_W      = BOARD_COLS * CELL_W;

    localparam logic [CELL_W-1:0] CELL_EMPTY = 6'd37; // colour code of a vacant cell

    // one board row, cell 0 is the leftmost column in the low bits
    typedef logic [BOARD_COLS-1:0][CELL_W-1:0] row_t;

    localparam row_t EMPTY_ROW = {BOARD_COLS{CELL_EMPTY}};

    typedef struct packed {
        logic       write; // 1 = write wdata, 0 = read
        logic [4:0] row;
        row_t       wdata;
    } ram_req_t;

endpackage

`default_nettype wire
